//--- lpif_link_ctl.f
+incdir+hw
hw/lpif_pkg.sv
hw/link_train_fsm.sv
hw/dstrm_beat_slicer.sv
hw/ustrm_beat_gather.sv
hw/lpif_link_ctl.sv
test/tb_lpif_link_ctl.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_lpif_link_ctl \
  -f lpif_link_ctl.f

out=$(./obj_dir/Vtb_lpif_link_ctl 2>&1) || true
echo "$out"
echo "$out" | grep -qx "TEST PASS"

//--- test/tb_lpif_link_ctl.sv
`include "lpif_defs.svh"

module tb_lpif_link_ctl
  import lpif_pkg::*;
  ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 3;
  localparam int DS_WORDS     = 4;
  localparam int US_WORDS     = 6;
  localparam int MAX_GAP      = 3;
  localparam int TRDY_WAIT    = 16;
  // cycles of all tests together, doubled for the watchdog
  localparam int RUN_CYCLES = RESET_CYCLES + 10 + DS_WORDS * 8 + 16 +
                              US_WORDS * `NUM_BEATS * (MAX_GAP + 1) + 4 + 12;

  logic                  lclk = 1'b0;
  logic                  rst_n;
  logic                  lp_irdy, pl_trdy, lp_linkerror;
  lpif_word_u            lp_data, pl_data;
  stream_id_t            lp_stream, pl_stream;
  logic                  pl_valid, dstrm_valid, ustrm_valid;
  beat_t                 dstrm_data, ustrm_data;
  protid_t               dstrm_protid, ustrm_protid;
  logic                  i_conf_done, align_done, align_err;
  logic [`AIB_LANES-1:0] ms_tx_transfer_en, sl_tx_transfer_en, wa_error;
  logic                  ns_mac_rdy, tx_online, rx_online, ctl_link_up, ctl_phy_err;
  logic [`AIB_LANES-1:0] ns_adapter_rstn;

  int                    mismatch_count = 0;
  int                    fail_count = 0;
  logic [31:0]           rng = 32'h3e4a;

  // upstream reference state
  logic [`LPIF_WORD_BITS-1:0] exp_asm, exp_pl_data;
  stream_id_t                 exp_pl_stream;
  logic                       pulse_due = 1'b0;
  int                         us_beat = 0;

  lpif_link_ctl dut (.*);

  always #(CLK_PERIOD / 2) lclk = ~lclk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic protid_t expected_protid(input stream_id_t s);
    if (s == `IO_STREAM_ID)
      return 2'h1;
    if (s == `ARB_MUX_STREAM_ID)
      return 2'h2;
    return 2'h0;   // cache and anything unknown
  endfunction

  function automatic stream_id_t expected_stream(input protid_t p);
    if (p == 2'h1)
      return `IO_STREAM_ID;
    if (p == 2'h2)
      return `ARB_MUX_STREAM_ID;
    return `MEM_CACHE_STREAM_ID;
  endfunction

  task automatic rand_word(output logic [`LPIF_WORD_BITS-1:0] w);
    for (int i = 0; i < `LPIF_WORD_BITS / 32; i++)
      begin
        rng = xorshift32(rng);
        w[32*i +: 32] = rng;
      end
  endtask

  task automatic check_eq(input string name, input logic [255:0] got,
                          input logic [255:0] exp);
    if (got !== exp)
      begin
        mismatch_count++;
        $display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      end
  endtask

  task automatic wait_trdy();
    int n;
    n = 0;
    while (!pl_trdy && n < TRDY_WAIT)
      begin
        @(negedge lclk);
        n++;
      end
    if (!pl_trdy)
      begin
        fail_count++;
        $display("pl_trdy did not rise within %0d cycles at %0t", TRDY_WAIT, $time);
      end
  endtask

  // one upstream cycle, checking the pulse owed by the previous one
  task automatic ustrm_step(input logic v, input beat_t d, input protid_t p);
    @(negedge lclk);
    check_eq("pl_valid", pl_valid, pulse_due);
    if (pulse_due)
      begin
        check_eq("pl_data", pl_data, exp_pl_data);
        check_eq("pl_stream", pl_stream, exp_pl_stream);
      end
    ustrm_valid = v;
    ustrm_data = d;
    ustrm_protid = p;
    pulse_due = 1'b0;
    if (v)
      begin
        exp_asm[`BEAT_BITS*us_beat +: `BEAT_BITS] = d;
        if (us_beat == `NUM_BEATS - 1)
          begin
            pulse_due = 1'b1;
            exp_pl_data = exp_asm;
            exp_pl_stream = expected_stream(p);
            us_beat = 0;
          end
        else
          us_beat++;
      end
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests

  task automatic test_bring_up();
    repeat (RESET_CYCLES) @(negedge lclk);
    check_eq("ctl_link_up", ctl_link_up, 0);
    check_eq("ctl_phy_err", ctl_phy_err, 0);
    check_eq("ns_mac_rdy", ns_mac_rdy, 0);
    check_eq("ns_adapter_rstn", ns_adapter_rstn, 0);
    check_eq("tx_online", tx_online, 0);
    check_eq("rx_online", rx_online, 0);
    check_eq("pl_trdy", pl_trdy, 0);
    check_eq("dstrm_valid", dstrm_valid, 0);
    check_eq("pl_valid", pl_valid, 0);
    rst_n = 1'b1;
    @(negedge lclk);   // phy init
    check_eq("ns_mac_rdy", ns_mac_rdy, 0);
    i_conf_done = 1'b1;
    @(negedge lclk);   // cfg
    check_eq("ns_mac_rdy", ns_mac_rdy, 1);
    check_eq("ns_adapter_rstn", ns_adapter_rstn, 0);
    i_conf_done = 1'b0;
    @(negedge lclk);   // calib
    check_eq("ns_adapter_rstn", ns_adapter_rstn, 4'hf);
    ms_tx_transfer_en = 4'hf;
    @(negedge lclk);   // only half the enables, still calib
    check_eq("tx_online", tx_online, 0);
    sl_tx_transfer_en = 4'hf;
    @(negedge lclk);
    check_eq("tx_online", tx_online, 1);
    check_eq("rx_online", rx_online, 1);
    check_eq("ctl_link_up", ctl_link_up, 0);
    check_eq("pl_trdy", pl_trdy, 0);
    align_done = 1'b1;
    @(negedge lclk);
    check_eq("ctl_link_up", ctl_link_up, 1);
    check_eq("ctl_phy_err", ctl_phy_err, 0);
    check_eq("pl_trdy", pl_trdy, 1);
    align_done = 1'b0;
  endtask

  task automatic test_dstrm_single();
    logic [`LPIF_WORD_BITS-1:0] w;
    stream_id_t                 s;
    for (int i = 0; i < DS_WORDS; i++)
      begin
        rand_word(w);
        rng = xorshift32(rng);
        s = (i == DS_WORDS - 1) ? 8'h5a : stream_id_t'(rng % 3 + 1);  // last one unknown
        wait_trdy();
        lp_irdy = 1'b1;
        lp_data = w;
        lp_stream = s;
        @(negedge lclk);
        check_eq("dstrm_valid", dstrm_valid, 0);
        lp_irdy = 1'b0;
        for (int b = 0; b < `NUM_BEATS; b++)
          begin
            @(negedge lclk);
            check_eq("dstrm_valid", dstrm_valid, 1);
            check_eq("dstrm_data", dstrm_data, w[`BEAT_BITS*b +: `BEAT_BITS]);
            check_eq("dstrm_protid", dstrm_protid, expected_protid(s));
          end
        @(negedge lclk);
        check_eq("dstrm_valid", dstrm_valid, 0);
      end
  endtask

  task automatic test_dstrm_back_to_back();
    logic [`LPIF_WORD_BITS-1:0] words [3];
    stream_id_t                 streams [3];
    int                         b;
    for (int i = 0; i < 3; i++)
      begin
        rand_word(words[i]);
        rng = xorshift32(rng);
        streams[i] = stream_id_t'(rng % 3 + 1);
      end
    wait_trdy();
    lp_irdy = 1'b1;
    lp_data = words[0];
    lp_stream = streams[0];
    // cycle c counts from the first acceptance
    for (int c = 0; c < 14; c++)
      begin
        @(negedge lclk);
        check_eq("dstrm_valid", dstrm_valid, c >= 1 && c <= 12);
        if (c >= 1 && c <= 12)
          begin
            b = c - 1;
            check_eq("dstrm_data", dstrm_data,
                     words[b/4][`BEAT_BITS*(b%4) +: `BEAT_BITS]);
            check_eq("dstrm_protid", dstrm_protid, expected_protid(streams[b/4]));
          end
        check_eq("pl_trdy", pl_trdy, c == 3 || c == 7 || c >= 11);  // last-beat cycles
        if (c == 0 || c == 4)
          begin
            lp_data = words[c/4 + 1];
            lp_stream = streams[c/4 + 1];
          end
        if (c == 8)
          lp_irdy = 1'b0;
      end
  endtask

  task automatic test_ustrm_gather();
    for (int w = 0; w < US_WORDS; w++)
      for (int b = 0; b < `NUM_BEATS; b++)
        begin
          rng = xorshift32(rng);
          repeat (rng % (MAX_GAP + 1)) ustrm_step(1'b0, '0, '0);
          rng = xorshift32(rng);
          ustrm_step(1'b1, {rng, ~rng}, (b == `NUM_BEATS - 1) ? protid_t'(w) : rng[9:8]);
        end
    ustrm_step(1'b0, '0, '0);
    ustrm_step(1'b0, '0, '0);
  endtask

  task automatic test_phy_error();
    check_eq("ctl_link_up", ctl_link_up, 1);
    wa_error = 4'h2;
    @(negedge lclk);
    check_eq("ctl_phy_err", ctl_phy_err, 1);
    check_eq("ctl_link_up", ctl_link_up, 0);
    check_eq("pl_trdy", pl_trdy, 0);
    check_eq("ns_mac_rdy", ns_mac_rdy, 1);
    check_eq("ns_adapter_rstn", ns_adapter_rstn, 4'hf);
    check_eq("tx_online", tx_online, 1);
    check_eq("rx_online", rx_online, 1);
    wa_error = 4'h0;
    for (int i = 0; i < 6; i++)
      begin
        @(negedge lclk);
        check_eq("ctl_phy_err", ctl_phy_err, 1);   // sticky
        check_eq("pl_trdy", pl_trdy, 0);
        check_eq("pl_valid", pl_valid, 0);
        rng = xorshift32(rng);
        ustrm_valid = (i < `NUM_BEATS);
        ustrm_data = {rng, rng};
        ustrm_protid = rng[1:0];
      end
    ustrm_valid = 1'b0;
    @(negedge lclk);
    check_eq("pl_valid", pl_valid, 0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog

  initial
    begin
      rst_n = 1'b0;
      lp_irdy = 1'b0;
      lp_data = '0;
      lp_stream = '0;
      lp_linkerror = 1'b0;
      ustrm_valid = 1'b0;
      ustrm_data = '0;
      ustrm_protid = '0;
      i_conf_done = 1'b0;
      ms_tx_transfer_en = '0;
      sl_tx_transfer_en = '0;
      wa_error = '0;
      align_done = 1'b0;
      align_err = 1'b0;
      exp_asm = '0;
      test_bring_up();
      test_dstrm_single();
      test_dstrm_back_to_back();
      test_ustrm_gather();
      test_phy_error();
      $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
      if (mismatch_count + fail_count == 0)
        $display("TEST PASS");
      else
        $display("TEST FAIL");
      $finish;
    end

  initial
    begin
      #(CLK_PERIOD * RUN_CYCLES * 2);
      $display("watchdog expired after %0d cycles, tests did not finish", RUN_CYCLES * 2);
      $display("TEST FAIL");
      $finish;
    end

endmodule

//--- hw/lpif_link_ctl.sv
`include "lpif_defs.svh"

module lpif_link_ctl
  import lpif_pkg::*;
  (
   input  logic                  lclk,
   input  logic                  rst_n,

   // lpif downstream
   input  logic                  lp_irdy,
   input  lpif_word_u            lp_data,
   input  stream_id_t            lp_stream,
   output logic                  pl_trdy,

   // lpif upstream
   output logic                  pl_valid,
   output lpif_word_u            pl_data,
   output stream_id_t            pl_stream,

   input  logic                  lp_linkerror,

   // phy beats
   output logic                  dstrm_valid,
   output beat_t                 dstrm_data,
   output protid_t               dstrm_protid,
   input  logic                  ustrm_valid,
   input  beat_t                 ustrm_data,
   input  protid_t               ustrm_protid,

   // phy control and status
   input  logic                  i_conf_done,
   input  logic [`AIB_LANES-1:0] ms_tx_transfer_en,
   input  logic [`AIB_LANES-1:0] sl_tx_transfer_en,
   input  logic [`AIB_LANES-1:0] wa_error,
   input  logic                  align_done,
   input  logic                  align_err,
   output logic                  ns_mac_rdy,
   output logic [`AIB_LANES-1:0] ns_adapter_rstn,
   output logic                  tx_online,
   output logic                  rx_online,

   output logic                  ctl_link_up,
   output logic                  ctl_phy_err
   );

  //////////////////////////////////////////////////////////////////////
  // bring-up

  link_train_fsm u_link_train_fsm
    (
     .lclk              (lclk),
     .rst_n             (rst_n),
     .i_conf_done       (i_conf_done),
     .ms_tx_transfer_en (ms_tx_transfer_en),
     .sl_tx_transfer_en (sl_tx_transfer_en),
     .wa_error          (wa_error),
     .align_done        (align_done),
     .align_err         (align_err),
     .lp_linkerror      (lp_linkerror),
     .ns_mac_rdy        (ns_mac_rdy),
     .ns_adapter_rstn   (ns_adapter_rstn),
     .tx_online         (tx_online),
     .rx_online         (rx_online),
     .ctl_link_up       (ctl_link_up),   // gates both data paths
     .ctl_phy_err       (ctl_phy_err)
     );

  //////////////////////////////////////////////////////////////////////
  // data paths

  dstrm_beat_slicer u_dstrm_beat_slicer
    (
     .lclk         (lclk),
     .rst_n        (rst_n),
     .ctl_link_up  (ctl_link_up),
     .lp_irdy      (lp_irdy),
     .lp_data      (lp_data),
     .lp_stream    (lp_stream),
     .pl_trdy      (pl_trdy),
     .dstrm_valid  (dstrm_valid),
     .dstrm_data   (dstrm_data),
     .dstrm_protid (dstrm_protid)
     );

  ustrm_beat_gather u_ustrm_beat_gather
    (
     .lclk         (lclk),
     .rst_n        (rst_n),
     .ctl_link_up  (ctl_link_up),
     .ustrm_valid  (ustrm_valid),
     .ustrm_data   (ustrm_data),
     .ustrm_protid (ustrm_protid),
     .pl_valid     (pl_valid),
     .pl_data      (pl_data),
     .pl_stream    (pl_stream)
     );

endmodule

//--- hw/ustrm_beat_gather.sv
`include "lpif_defs.svh"

module ustrm_beat_gather
  import lpif_pkg::*;
  (
   input  logic       lclk,
   input  logic       rst_n,
   input  logic       ctl_link_up,

   // phy side strobe
   input  logic       ustrm_valid,
   input  beat_t      ustrm_data,
   input  protid_t    ustrm_protid,

   // lpif side
   output logic       pl_valid,
   output lpif_word_u pl_data,
   output stream_id_t pl_stream
   );

  lpif_word_u                asm_word;
  lpif_word_u                d_asm_word;
  logic [`BEAT_CNT_BITS-1:0] beat_idx;
  logic                      take;
  logic                      last_beat;

  assign take = ustrm_valid & ctl_link_up;  // strobes ignored with link down
  assign last_beat = (beat_idx == `BEAT_CNT_BITS'(`NUM_BEATS - 1));

  // current beat merged into the partial word
  always_comb
    begin
      d_asm_word = asm_word;
      d_asm_word.beats[beat_idx] = ustrm_data;
    end

  //////////////////////////////////////////////////////////////////////
  // beat counting

  always_ff @(posedge lclk or negedge rst_n)
    if (~rst_n)
      begin
        beat_idx <= '0;
        pl_valid <= 1'b0;
      end
    else
      begin
        pl_valid <= take & last_beat;
        if (~ctl_link_up)
          beat_idx <= '0;   // restart at beat 0 on next bring-up
        else if (take)
          begin
            if (last_beat)
              beat_idx <= '0;
            else
              beat_idx <= beat_idx + 1'b1;
          end
      end

  always_ff @(posedge lclk)
    begin
      if (take)
        asm_word <= d_asm_word;
      if (take & last_beat)
        begin
          pl_data <= d_asm_word;
          pl_stream <= protid_to_stream(ustrm_protid);
        end
    end

  //////////////////////////////////////////////////////////////////////
  // checks

  // a full word takes at least NUM_BEATS strobes
  a_valid_single_pulse :
    assert property (@(posedge lclk) disable iff (~rst_n)
                     pl_valid |=> ~pl_valid)
    else $error("pl_valid high on two consecutive cycles");

endmodule

//--- hw/dstrm_beat_slicer.sv
`include "lpif_defs.svh"

module dstrm_beat_slicer
  import lpif_pkg::*;
  (
   input  logic       lclk,
   input  logic       rst_n,
   input  logic       ctl_link_up,

   // lpif side
   input  logic       lp_irdy,
   input  lpif_word_u lp_data,
   input  stream_id_t lp_stream,
   output logic       pl_trdy,

   // phy side, no back-pressure
   output logic       dstrm_valid,
   output beat_t      dstrm_data,
   output protid_t    dstrm_protid
   );

  lpif_word_u                hold_word;    // word being sliced
  protid_t                   hold_protid;

  logic                      busy;
  logic [`BEAT_CNT_BITS-1:0] beat_idx;     // beats left after the selected one
  logic [`BEAT_CNT_BITS-1:0] beat_sel;
  logic                      last_beat;
  logic                      accept;

  // last beat leaves the holding register this cycle
  assign last_beat = busy & (beat_idx == '0);

  // take a new word while idle or as the last beat goes out
  assign pl_trdy = ctl_link_up & (~busy | last_beat);
  assign accept = lp_irdy & pl_trdy;

  assign beat_sel = `BEAT_CNT_BITS'(`NUM_BEATS - 1) - beat_idx;

  //////////////////////////////////////////////////////////////////////
  // beat sequencing

  always_ff @(posedge lclk or negedge rst_n)
    if (~rst_n)
      begin
        busy <= 1'b0;
        beat_idx <= '0;
        dstrm_valid <= 1'b0;
      end
    else
      begin
        dstrm_valid <= busy;
        if (accept)
          begin
            busy <= 1'b1;
            beat_idx <= `BEAT_CNT_BITS'(`NUM_BEATS - 1);
          end
        else if (last_beat)
          busy <= 1'b0;
        else if (busy)
          beat_idx <= beat_idx - 1'b1;
      end

  // capture and beat output
  always_ff @(posedge lclk)
    begin
      if (accept)
        begin
          hold_word <= lp_data;
          hold_protid <= stream_to_protid(lp_stream);
        end
      if (busy)
        begin
          dstrm_data <= hold_word.beats[beat_sel];
          dstrm_protid <= hold_protid;
        end
    end

  //////////////////////////////////////////////////////////////////////
  // checks

  a_no_trdy_link_down :
    assert property (@(posedge lclk) disable iff (~rst_n)
                     ~ctl_link_up |-> ~pl_trdy)
    else $error("pl_trdy high with link down");

  // each beat on the phy side traces back to an acceptance 2..5 edges earlier
  a_valid_bounded :
    assert property (@(posedge lclk) disable iff (~rst_n)
                     dstrm_valid |-> ($past(accept, 2) | $past(accept, 3) |
                                      $past(accept, 4) | $past(accept, 5)))
    else $error("dstrm_valid longer than one word without acceptance");

endmodule

//--- hw/link_train_fsm.sv
`include "lpif_defs.svh"

module link_train_fsm
  import lpif_pkg::*;
  (
   input  logic                  lclk,
   input  logic                  rst_n,

   // phy status
   input  logic                  i_conf_done,
   input  logic [`AIB_LANES-1:0] ms_tx_transfer_en,
   input  logic [`AIB_LANES-1:0] sl_tx_transfer_en,
   input  logic [`AIB_LANES-1:0] wa_error,
   input  logic                  align_done,
   input  logic                  align_err,
   input  logic                  lp_linkerror,

   // phy control
   output logic                  ns_mac_rdy,
   output logic [`AIB_LANES-1:0] ns_adapter_rstn,
   output logic                  tx_online,
   output logic                  rx_online,

   output logic                  ctl_link_up,
   output logic                  ctl_phy_err
   );

  ctl_state_e            ctl_state, d_ctl_state;

  logic                  d_ns_mac_rdy;
  logic [`AIB_LANES-1:0] d_ns_adapter_rstn;
  logic                  d_tx_online;
  logic                  d_rx_online;

  logic                  xfer_en_all;
  logic                  phy_err;

  assign xfer_en_all = &{ms_tx_transfer_en, sl_tx_transfer_en};

  // error sources only matter once the link is up
  assign phy_err = ctl_link_up &
                   (~xfer_en_all | (|wa_error) | align_err | lp_linkerror);

  assign ctl_link_up = (ctl_state == CTL_LINK_UP);
  assign ctl_phy_err = (ctl_state == CTL_PHY_ERR);

  //////////////////////////////////////////////////////////////////////
  // bring-up sequence

  always_comb
    begin
      d_ctl_state = ctl_state;
      d_ns_mac_rdy = ns_mac_rdy;
      d_ns_adapter_rstn = ns_adapter_rstn;
      d_tx_online = tx_online;
      d_rx_online = rx_online;
      case (ctl_state)
        CTL_IDLE:
          d_ctl_state = CTL_PHY_INIT;
        CTL_PHY_INIT:
          if (i_conf_done)
            begin
              d_ns_mac_rdy = 1'b1;
              d_ctl_state = CTL_CFG;
            end
        CTL_CFG:
          begin
            d_ns_adapter_rstn = {`AIB_LANES{1'b1}};  // release all lanes together
            d_ctl_state = CTL_CALIB;
          end
        CTL_CALIB:
          if (xfer_en_all)
            begin
              d_tx_online = 1'b1;
              d_rx_online = 1'b1;
              d_ctl_state = CTL_WAIT_ALIGN;
            end
        CTL_WAIT_ALIGN:
          if (align_done)
            d_ctl_state = CTL_LINK_UP;
        CTL_LINK_UP:
          if (phy_err)
            d_ctl_state = CTL_PHY_ERR;
        CTL_PHY_ERR:
          d_ctl_state = CTL_PHY_ERR;  // sticky until reset
        default:
          d_ctl_state = CTL_IDLE;
      endcase
    end

  always_ff @(posedge lclk or negedge rst_n)
    if (~rst_n)
      begin
        ctl_state <= CTL_IDLE;
        ns_mac_rdy <= 1'b0;
        ns_adapter_rstn <= '0;
        tx_online <= 1'b0;
        rx_online <= 1'b0;
      end
    else
      begin
        ctl_state <= d_ctl_state;
        ns_mac_rdy <= d_ns_mac_rdy;
        ns_adapter_rstn <= d_ns_adapter_rstn;
        tx_online <= d_tx_online;
        rx_online <= d_rx_online;
      end

  //////////////////////////////////////////////////////////////////////
  // checks

  a_rstn_released_in_link_up :
    assert property (@(posedge lclk) disable iff (~rst_n)
                     ctl_link_up |-> &ns_adapter_rstn)
    else $error("adapter reset still asserted with link up");

endmodule

//--- hw/lpif_pkg.sv
`include "lpif_defs.svh"

package lpif_pkg;

  typedef enum logic [2:0]
    {
     CTL_IDLE       = 3'h0,
     CTL_PHY_INIT   = 3'h1,
     CTL_CFG        = 3'h2,
     CTL_CALIB      = 3'h3,
     CTL_WAIT_ALIGN = 3'h4,
     CTL_LINK_UP    = 3'h5,
     CTL_PHY_ERR    = 3'h6
    } ctl_state_e;

  typedef logic [1:0]            protid_t;
  typedef logic [7:0]            stream_id_t;
  typedef logic [`BEAT_BITS-1:0] beat_t;

  localparam protid_t PROTID_CACHE   = 2'h0;
  localparam protid_t PROTID_IO      = 2'h1;
  localparam protid_t PROTID_ARB_MUX = 2'h2;

  // flat on the link layer side, by beat toward the phy
  typedef union packed
    {
     logic [`LPIF_WORD_BITS-1:0] flat;
     beat_t [`NUM_BEATS-1:0]     beats;   // beat 0 in the low bits
    } lpif_word_u;

  function automatic protid_t stream_to_protid(input stream_id_t stream);
    case (stream)
      `MEM_CACHE_STREAM_ID: return PROTID_CACHE;
      `IO_STREAM_ID:        return PROTID_IO;
      `ARB_MUX_STREAM_ID:   return PROTID_ARB_MUX;
      default:              return PROTID_CACHE;
    endcase
  endfunction

  function automatic stream_id_t protid_to_stream(input protid_t protid);
    case (protid)
      PROTID_CACHE:   return `MEM_CACHE_STREAM_ID;
      PROTID_IO:      return `IO_STREAM_ID;
      PROTID_ARB_MUX: return `ARB_MUX_STREAM_ID;
      default:        return `MEM_CACHE_STREAM_ID;  // reserved code
    endcase
  endfunction

endpackage

//--- hw/lpif_defs.svh
`ifndef LPIF_DEFS_SVH
`define LPIF_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// datapath sizing, x4 lanes with 64-bit beats

`define LPIF_WORD_BITS 256
`define BEAT_BITS      64
`define NUM_BEATS      4
`define BEAT_CNT_BITS  2   // log2 of NUM_BEATS

`define AIB_LANES      4

//////////////////////////////////////////////////////////////////////
// lpif stream ids

`define MEM_CACHE_STREAM_ID 8'h1
`define IO_STREAM_ID        8'h2
`define ARB_MUX_STREAM_ID   8'h3

`endif
